// ==== common/mod113_defines.svh ====
`ifndef MOD113_DEFINES_SVH
`define MOD113_DEFINES_SVH

// Prime modulus of the field.
`define MOD113_MODULUS 113

// Weight of bit 8 after reduction, 128 mod 113.
`define MOD113_FOLD 15

// Host register map.
`define MOD113_ADR_A 0
`define MOD113_ADR_B 1
`define MOD113_ADR_CTRL 2
`define MOD113_ADR_STATUS 3
`define MOD113_ADR_RESULT 4

// Exponent width, also the number of square-and-multiply steps.
`define MOD113_EXP_BITS 7

`endif

// ==== common/mod113_pkg.sv ====
`default_nettype none

package mod113_pkg;

  // Element of GF(113).
  // Bits are numbered from 1 so the digit split reads bits 3:1, 6:4 and 7.
  typedef logic [7:1] residue_t;

  // Operation codes as written to CTRL bits 1:0.
  typedef enum logic [1:0] {
    op_mul = 2'd0,
    op_add = 2'd1,
    op_sub = 2'd2,
    op_exp = 2'd3
  } op_t;

  // Index into the host register map.
  typedef logic [2:0] reg_addr_t;

endpackage

`default_nettype wire

// ==== mult/mod113_fold.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module mod113_fold (
  input  logic [10:1]          sum,
  output mod113_pkg::residue_t r
);

  logic [8:1] first;
  logic [8:1] second;

  // Bits 10:8 carry weight 128, which is 15 in the field.
  assign first = sum[7:1] + sum[10:8] * 8'(`MOD113_FOLD);

  // A carry out of bit 7 can still remain, so fold it once more.
  assign second = first[8] ? {1'b0, first[7:1]} + 8'(`MOD113_FOLD) : first;

  // Value is now below 128, one subtraction is enough.
  always_comb
  begin
    if (second >= 8'(`MOD113_MODULUS))
      r = 7'(second - 8'(`MOD113_MODULUS));
    else
      r = second[7:1];
  end

endmodule

`default_nettype wire

// ==== mult/mod113_mult.sv ====
`default_nettype none
`timescale 1ns/1ns

module mod113_mult (
  input  mod113_pkg::residue_t a,
  input  mod113_pkg::residue_t b,
  output mod113_pkg::residue_t p
);

  localparam int unsigned n_terms = 9;

  // Digit weights reduced mod 113.
  localparam logic [10:1] wt_8  = 10'd8;
  localparam logic [10:1] wt_64 = 10'd64;
  localparam logic [10:1] wt_60 = 10'd60;
  localparam logic [10:1] wt_28 = 10'd28;

  logic [3:1] a_lo;
  logic [3:1] a_mid;
  logic [3:1] b_lo;
  logic [3:1] b_mid;
  logic       a_hi;
  logic       b_hi;
  logic [6:1] mid_prod;

  logic [10:1]          raw  [n_terms];
  mod113_pkg::residue_t term [n_terms];
  logic [10:1]          total;

  // Digits of weight 1, 8 and 64.
  assign a_lo  = a[3:1];
  assign a_mid = a[6:4];
  assign a_hi  = a[7];
  assign b_lo  = b[3:1];
  assign b_mid = b[6:4];
  assign b_hi  = b[7];

  assign mid_prod = a_mid * b_mid;

  // Nine digit products with their weights applied.
  assign raw[0] = a_lo * b_lo;
  assign raw[1] = a_lo * b_mid * wt_8;
  assign raw[2] = a_mid * b_lo * wt_8;
  assign raw[3] = b_hi ? a_lo * wt_64 : '0;
  assign raw[4] = a_hi ? b_lo * wt_64 : '0;
  // 8 * 8 gives weight 64; the upper digit of the product picks up 512, i.e. 60.
  assign raw[5] = mid_prod[6:4] * wt_60 + mid_prod[3:1] * wt_64;
  assign raw[6] = b_hi ? a_mid * wt_60 : '0;
  assign raw[7] = a_hi ? b_mid * wt_60 : '0;
  assign raw[8] = (a_hi && b_hi) ? wt_28 : '0;

  // Reduce each term so the nine together fit in 10 bits.
  for (genvar i = 0; i < n_terms; i++)
  begin : g_term
    mod113_fold i_fold (
      .sum (raw[i]),
      .r   (term[i])
    );
  end

  always_comb
  begin
    total = '0;
    for (int i = 0; i < n_terms; i++)
      total = total + 10'(term[i]);
  end

  // Final fold and correction of the term sum.
  mod113_fold i_fold_sum (
    .sum (total),
    .r   (p)
  );

endmodule

`default_nettype wire

// ==== hw/wb_decode.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module wb_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  mod113_pkg::reg_addr_t adr,
  input  logic [7:0]            dat_w,
  output logic                  ack,
  input  logic                  busy,
  output mod113_pkg::residue_t  operand_a,
  output mod113_pkg::residue_t  operand_b,
  output mod113_pkg::op_t       op,
  output logic                  start,
  output mod113_pkg::reg_addr_t rd_adr
);

  logic req;
  logic ctrl_wr;

  // Reduce a 7-bit host value into the field.
  function automatic mod113_pkg::residue_t reduce_in(input logic [6:0] v);
    if (v >= 7'(`MOD113_MODULUS))
      return v - 7'(`MOD113_MODULUS);
    return v;
  endfunction

  // New request only while ack is low.
  assign req = cyc && stb && !ack;
  assign ctrl_wr = req && we && (adr == 3'(`MOD113_ADR_CTRL));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack    <= 1'b0;
      start  <= 1'b0;
      rd_adr <= '0;
    end
    else
    begin
      ack   <= req;
      // Start lines up with ack. Busy units drop the command.
      start <= ctrl_wr && !busy;
      if (req)
        rd_adr <= adr;
    end
  end

  // Register writes. Bit 7 of the data is ignored.
  always_ff @(posedge clk)
  begin
    if (req && we)
    begin
      case (adr)
        `MOD113_ADR_A:    operand_a <= reduce_in(dat_w[6:0]);
        `MOD113_ADR_B:    operand_b <= reduce_in(dat_w[6:0]);
        `MOD113_ADR_CTRL:
        begin
          if (!busy)
            op <= mod113_pkg::op_t'(dat_w[1:0]);
        end
        default:          ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/mod_execute.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module mod_execute (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  mod113_pkg::residue_t operand_a,
  input  mod113_pkg::residue_t operand_b,
  input  mod113_pkg::op_t      op,
  output logic                 busy,
  output logic                 finish,
  output mod113_pkg::residue_t result
);

  mod113_pkg::residue_t acc;
  mod113_pkg::residue_t base;
  mod113_pkg::residue_t exp_sh;
  mod113_pkg::residue_t acc_cur;
  mod113_pkg::residue_t base_cur;
  mod113_pkg::residue_t exp_cur;
  mod113_pkg::residue_t sq;
  mod113_pkg::residue_t m1_x;
  mod113_pkg::residue_t m1_p;
  mod113_pkg::residue_t acc_nxt;
  mod113_pkg::residue_t add_res;

  logic [7:0] addend;
  logic [7:0] raw_sum;
  logic [7:0] corr;
  logic       running;
  logic [2:0] cnt;

  // First exp step runs on the start cycle from the operands directly.
  assign acc_cur  = start ? mod113_pkg::residue_t'(1) : acc;
  assign base_cur = start ? operand_a : base;
  assign exp_cur  = start ? operand_b : exp_sh;

  mod113_mult i_mult_sq (
    .a (acc_cur),
    .b (acc_cur),
    .p (sq)
  );

  // Second multiplier also serves the plain multiply.
  assign m1_x = (start && op == mod113_pkg::op_mul) ? operand_b : sq;

  mod113_mult i_mult_base (
    .a (m1_x),
    .b (base_cur),
    .p (m1_p)
  );

  // Exponent MSB selects square or square times base.
  assign acc_nxt = exp_cur[7] ? m1_p : sq;

  // Subtract as a + (113 - b).
  assign addend  = (op == mod113_pkg::op_sub) ? 8'(`MOD113_MODULUS) - 8'(operand_b)
                                               : 8'(operand_b);
  assign raw_sum = 8'(operand_a) + addend;
  assign corr    = (raw_sum >= 8'(`MOD113_MODULUS)) ? raw_sum - 8'(`MOD113_MODULUS)
                                                     : raw_sum;
  assign add_res = corr[6:0];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      finish  <= 1'b0;
      running <= 1'b0;
      cnt     <= '0;
      result  <= '0;
    end
    else
    begin
      finish <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        if (op == mod113_pkg::op_exp)
        begin
          running <= 1'b1;
          cnt     <= 3'(`MOD113_EXP_BITS - 1);
        end
        else
        begin
          finish <= 1'b1;
          result <= (op == mod113_pkg::op_mul) ? m1_p : add_res;
        end
      end
      else if (running)
      begin
        cnt <= cnt - 1'b1;
        // Last exponent bit.
        if (cnt == 3'd1)
        begin
          running <= 1'b0;
          finish  <= 1'b1;
          result  <= acc_nxt;
        end
      end
      else if (finish)
        busy <= 1'b0;
    end
  end

  // Exponentiation datapath.
  always_ff @(posedge clk)
  begin
    if ((start && op == mod113_pkg::op_exp) || running)
    begin
      acc    <= acc_nxt;
      base   <= base_cur;
      exp_sh <= {exp_cur[6:1], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== hw/result_regs.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module result_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  finish,
  input  logic                  busy,
  input  mod113_pkg::residue_t  result,
  input  mod113_pkg::reg_addr_t rd_adr,
  input  mod113_pkg::residue_t  operand_a,
  input  mod113_pkg::residue_t  operand_b,
  output logic [7:0]            dat_r
);

  logic                 done;
  mod113_pkg::residue_t last;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      done <= 1'b0;
      last <= '0;
    end
    else
    begin
      // A new command clears done.
      if (start)
        done <= 1'b0;
      else if (finish)
        done <= 1'b1;
      if (finish)
        last <= result;
    end
  end

  // Read data for the address captured with the request.
  always_comb
  begin
    case (rd_adr)
      `MOD113_ADR_A:      dat_r = {1'b0, operand_a};
      `MOD113_ADR_B:      dat_r = {1'b0, operand_b};
      `MOD113_ADR_STATUS: dat_r = {6'b0, done, busy};
      `MOD113_ADR_RESULT: dat_r = {1'b0, last};
      default:            dat_r = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mod113_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module mod113_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  logic [2:0] adr,
  input  logic [7:0] dat_w,
  output logic [7:0] dat_r,
  output logic       ack
);

  mod113_pkg::residue_t  operand_a;
  mod113_pkg::residue_t  operand_b;
  mod113_pkg::op_t       op;
  mod113_pkg::residue_t  result;
  mod113_pkg::reg_addr_t rd_adr;
  logic                  start;
  logic                  busy;
  logic                  finish;

  // Wishbone slave and register writes.
  wb_decode i_wb_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .ack       (ack),
    .busy      (busy),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .start     (start),
    .rd_adr    (rd_adr)
  );

  mod_execute i_mod_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .busy      (busy),
    .finish    (finish),
    .result    (result)
  );

  // Status, result and read mux.
  result_regs i_result_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .finish    (finish),
    .busy      (busy),
    .result    (result),
    .rd_adr    (rd_adr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .dat_r     (dat_r)
  );

endmodule

`default_nettype wire

// ==== test/mod113_props.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module mod113_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 cyc,
  input logic                 stb,
  input logic                 ack,
  input logic                 busy,
  input logic                 finish,
  input mod113_pkg::residue_t result
);

  // Number of assertion failures so far.
  int fail_count = 0;

  // Single-cycle ack.
  ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
  else
  begin
    fail_count++;
    $error("ack high two cycles in a row");
  end

  // Ack answers a request from the cycle before.
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> $past(cyc && stb))
  else
  begin
    fail_count++;
    $error("ack without a preceding cyc and stb");
  end

  // Result is a reduced residue.
  result_range: assert property (@(posedge clk) disable iff (!rst_n)
    finish |-> (result < 7'(`MOD113_MODULUS)))
  else
  begin
    fail_count++;
    $error("result not below the modulus while finish is high");
  end

  // Longest command is the exponentiation.
  busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> ##[1:`MOD113_EXP_BITS] !busy)
  else
  begin
    fail_count++;
    $error("busy stayed high too long");
  end

endmodule

bind mod113_top mod113_props i_mod113_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .cyc    (cyc),
  .stb    (stb),
  .ack    (ack),
  .busy   (busy),
  .finish (finish),
  .result (result)
);

`default_nettype wire

// ==== test/tb_mod113.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "mod113_defines.svh"

module tb_mod113;

  localparam int clk_period      = 4;
  localparam int modulus         = `MOD113_MODULUS;
  localparam int n_pairs         = 12;
  localparam int n_random        = 16;
  localparam int n_rows          = n_pairs * 4 + n_random + 1;
  localparam int watchdog_cycles = n_rows * 40 + 100;

  typedef struct {
    mod113_pkg::op_t      op;
    logic [7:0]           a;
    logic [7:0]           b;
    mod113_pkg::residue_t expected;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       cyc;
  logic       stb;
  logic       we;
  logic [2:0] adr;
  logic [7:0] dat_w;
  logic [7:0] dat_r;
  logic       ack;

  int   cycle = 0;
  int   ack_cycle = 0;
  int   seed = 32'h6d05_d474;
  row_t rows [$];

  // Edge operands, including raw values above the modulus and bit 7 set.
  logic [7:0] pair_a [n_pairs] = '{8'd0, 8'd0, 8'd1, 8'd1, 8'd112, 8'd112,
                                   8'd60, 8'd100, 8'd56, 8'd5, 8'd120, 8'h85};
  logic [7:0] pair_b [n_pairs] = '{8'd0, 8'd5, 8'd1, 8'd112, 8'd1, 8'd112,
                                   8'd70, 8'd50, 8'd57, 8'd0, 8'd127, 8'd3};

  mod113_top i_mod113_top (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_residue(input string name, input mod113_pkg::residue_t expected,
                               input mod113_pkg::residue_t actual);
    if (actual !== expected)
      stop_run($sformatf("[ERROR] t=%0t %s expected %0d actual %0d",
                         $time, name, expected, actual));
  endtask

  task automatic check_status(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    if (actual !== expected)
      stop_run($sformatf("[ERROR] t=%0t %s expected 0x%02h actual 0x%02h",
                         $time, name, expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stop_run($sformatf("[ERROR] t=%0t %s expected %b actual %b",
                         $time, name, expected, actual));
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected)
      stop_run($sformatf("[ERROR] t=%0t %s expected %0d actual %0d",
                         $time, name, expected, actual));
  endtask

  // Host value as the register keeps it.
  function automatic int reduce_host(input logic [7:0] v);
    int r;
    r = int'(v[6:0]);
    if (r >= modulus)
      r = r - modulus;
    return r;
  endfunction

  // Integer model of the four operations.
  function automatic int model_result(input mod113_pkg::op_t op, input int a, input int b);
    int r;
    r = 1;
    case (op)
      mod113_pkg::op_mul: r = (a * b) % modulus;
      mod113_pkg::op_add: r = (a + b) % modulus;
      mod113_pkg::op_sub: r = (a - b + modulus) % modulus;
      default:
      begin
        for (int i = 0; i < b; i++)
          r = (r * a) % modulus;
      end
    endcase
    return r;
  endfunction

  task automatic add_row(input mod113_pkg::op_t op, input logic [7:0] a,
                         input logic [7:0] b);
    row_t r;
    r.op = op;
    r.a = a;
    r.b = b;
    r.expected = mod113_pkg::residue_t'(model_result(op, reduce_host(a), reduce_host(b)));
    rows.push_back(r);
  endtask

  task automatic build_rows();
    logic [1:0] r_op;
    logic [7:0] r_a;
    logic [7:0] r_b;
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < n_pairs; i++)
        add_row(mod113_pkg::op_t'(k), pair_a[i], pair_b[i]);
    for (int i = 0; i < n_random; i++)
    begin
      r_op = 2'($random(seed));
      r_a = 8'($random(seed));
      r_b = 8'($random(seed));
      add_row(mod113_pkg::op_t'(r_op), r_a, r_b);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the ack edge.
  task automatic write_reg(input logic [2:0] a, input logic [7:0] d);
    int waited;
    waited = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = a;
    dat_w = d;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 16)
        stop_run($sformatf("No ack for a write to address %0d.", a));
    end
    while (ack !== 1'b1);
    ack_cycle = cycle;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] a, output logic [7:0] d);
    int waited;
    waited = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = a;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 16)
        stop_run($sformatf("No ack for a read from address %0d.", a));
    end
    while (ack !== 1'b1);
    d = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  // Cycles counted from the end of the CTRL ack cycle.
  task automatic wait_done(input int from_cycle, input int latency);
    int n;
    @(posedge clk);
    #1;
    while (i_mod113_top.i_result_regs.done !== 1'b1)
    begin
      check_flag("busy", 1'b1, i_mod113_top.busy);
      @(posedge clk);
      #1;
      if (cycle - from_cycle > 3 * `MOD113_EXP_BITS)
        stop_run("Done was never set after a command was started.");
    end
    n = cycle - from_cycle - 1;
    check_latency("done latency", latency, n);
  endtask

  task automatic run_row(input row_t r);
    logic [7:0] data;
    write_reg(3'(`MOD113_ADR_A), r.a);
    write_reg(3'(`MOD113_ADR_B), r.b);
    write_reg(3'(`MOD113_ADR_CTRL), {6'b0, r.op});
    wait_done(ack_cycle, (r.op == mod113_pkg::op_exp) ? `MOD113_EXP_BITS : 1);
    read_reg(3'(`MOD113_ADR_STATUS), data);
    check_status("status", 8'h02, data);
    read_reg(3'(`MOD113_ADR_RESULT), data);
    check_residue("result", r.expected, data[6:0]);
  endtask

  initial
  begin : main
    logic [7:0] data;
    int         saved;
    mod113_pkg::residue_t busy_ref;
    rst_n = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    build_rows();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state after reset.
    read_reg(3'(`MOD113_ADR_STATUS), data);
    check_status("status", 8'h00, data);
    read_reg(3'(`MOD113_ADR_RESULT), data);
    check_residue("result", '0, data[6:0]);

    // Operand reduction on write, bit 7 ignored.
    for (int v = 108; v < 128; v++)
    begin
      write_reg(3'(`MOD113_ADR_A), 8'(v));
      write_reg(3'(`MOD113_ADR_B), 8'(v) | 8'h80);
      read_reg(3'(`MOD113_ADR_A), data);
      check_residue("operand_a", mod113_pkg::residue_t'(reduce_host(8'(v))), data[6:0]);
      read_reg(3'(`MOD113_ADR_B), data);
      check_residue("operand_b", mod113_pkg::residue_t'(reduce_host(8'(v))), data[6:0]);
    end

    foreach (rows[i])
      run_row(rows[i]);

    // CTRL write during an exponentiation is dropped.
    busy_ref = mod113_pkg::residue_t'(model_result(mod113_pkg::op_exp, 3, 100));
    write_reg(3'(`MOD113_ADR_A), 8'd3);
    write_reg(3'(`MOD113_ADR_B), 8'd100);
    write_reg(3'(`MOD113_ADR_CTRL), {6'b0, mod113_pkg::op_exp});
    saved = ack_cycle;
    write_reg(3'(`MOD113_ADR_CTRL), {6'b0, mod113_pkg::op_mul});
    wait_done(saved, `MOD113_EXP_BITS);
    read_reg(3'(`MOD113_ADR_STATUS), data);
    check_status("status", 8'h02, data);
    read_reg(3'(`MOD113_ADR_RESULT), data);
    check_residue("result", busy_ref, data[6:0]);

    if (i_mod113_top.i_mod113_props.fail_count == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
      stop_run("Assertion failures were reported during the run.");
  end

  initial
  begin : watchdog
    #(watchdog_cycles * clk_period);
    stop_run("Watchdog expired before the tests completed.");
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/mod113_pkg.sv
mult/mod113_fold.sv
mult/mod113_mult.sv
hw/wb_decode.sv
hw/mod_execute.sv
hw/result_regs.sv
hw/mod113_top.sv
test/mod113_props.sv
test/tb_mod113.sv
